/* src/up_pkg.sv */
`default_nettype none

package up_pkg;

   localparam int DATA_W    = 8;
   localparam int MEM_DEPTH = 256;
   localparam int REG_COUNT = 4;
   localparam int REG_IDX_W = $clog2(REG_COUNT);

   typedef logic [DATA_W-1:0] word_t;

   localparam word_t PC_RESET = word_t'(8);    // High nibble of byte 4
   localparam word_t SP_RESET = word_t'(255);  // Stack grows down

   typedef enum logic [3:0] {
      IDLE, LOAD_0, LOAD_1, LOAD_2, LOAD_3, LOAD_4,
      FETCH, DECODE, EXEC_1, EXEC_2, EXEC_3
   } state_e;

   typedef enum logic [3:0] {
      ADD       = 4'h0,
      SUB       = 4'h1,
      MUL       = 4'h2,
      NAND      = 4'h3,
      SWAP_01   = 4'h4,
      SWAP_12   = 4'h5,
      SWAP_23   = 4'h6,
      BEQ       = 4'h7,
      NOP_8     = 4'h8,
      PUSH_PC   = 4'h9,
      POP_R2    = 4'hA,
      PUSH_R2   = 4'hB,
      LOAD      = 4'hC,
      STORE     = 4'hD,
      RELOAD_R0 = 4'hE,
      NOP_F     = 4'hF
   } opcode_e;

   typedef enum logic [4:0] {
      RES_SUM, RES_DIFF, RES_PROD, RES_NAND,
      RES_XOR_01, RES_XOR_12, RES_XOR_23,
      RES_CONST_0, RES_CONST_1, RES_CONST_2, RES_CONST_3,
      RES_PC_HALF,   // Byte address of current nibble
      RES_PC_INC, RES_PC_DEC,
      RES_R3, RES_R2,
      RES_SP, RES_SP_INC, RES_SP_DEC,
      RES_MEM
   } result_e;

   typedef struct packed {
      logic                 from_result;  // Else memory data
      logic [REG_IDX_W-1:0] idx;
   } reg_sel_t;

   typedef struct packed {
      result_e  res;
      logic     ir_we;
      logic     pc_we;
      logic     sp_we;
      logic     rb_we;
      reg_sel_t rb_sel;
      logic     mem_we;
      logic     ale;
   } ctrl_t;

   typedef struct packed {
      logic  valid;
      word_t addr;
      word_t data;
   } mem_write_t;

endpackage

`default_nettype wire

/* src/up_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module up_controller (
   input  logic            clk,
   input  logic            nRst,
   input  logic            start,
   input  up_pkg::opcode_e ir,
   input  logic            z,
   output up_pkg::ctrl_t   ctrl
);

   import up_pkg::*;

   state_e                 state;
   result_e                swap_res;
   logic [REG_IDX_W-1:0]   swap_lo;
   logic [REG_IDX_W-1:0]   swap_hi;

   function automatic reg_sel_t dest(input logic from_result,
                                     input logic [REG_IDX_W-1:0] idx);
      reg_sel_t sel;
      sel.from_result = from_result;
      sel.idx         = idx;
      return sel;
   endfunction

   // Swap pair follows the opcode's low bits
   always_comb begin
      case (ir)
         SWAP_12: swap_res = RES_XOR_12;
         SWAP_23: swap_res = RES_XOR_23;
         default: swap_res = RES_XOR_01;
      endcase
   end

   assign swap_lo = ir[REG_IDX_W-1:0];
   assign swap_hi = swap_lo + 1'b1;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE:   if (start) state <= LOAD_0;
            LOAD_0: state <= LOAD_1;
            LOAD_1: state <= LOAD_2;
            LOAD_2: state <= LOAD_3;
            LOAD_3: state <= LOAD_4;
            LOAD_4: state <= FETCH;
            FETCH:  state <= DECODE;
            DECODE: state <= EXEC_1;
            EXEC_1: begin
               case (ir)
                  ADD, SUB, MUL, NAND, BEQ, NOP_8, NOP_F: state <= FETCH;
                  default: state <= EXEC_2;
               endcase
            end
            EXEC_2: begin
               case (ir)
                  SWAP_01, SWAP_12, SWAP_23, PUSH_PC, PUSH_R2: state <= EXEC_3;
                  default: state <= FETCH;
               endcase
            end
            default: state <= FETCH;
         endcase
      end
   end

   always_comb begin
      ctrl     = '0;
      ctrl.res = RES_MEM;
      case (state)
         LOAD_0: begin
            ctrl.res = RES_CONST_0;
            ctrl.ale = 1'b1;
         end
         LOAD_1, LOAD_2, LOAD_3, LOAD_4: begin
            ctrl.ale    = 1'b1;
            ctrl.rb_we  = 1'b1;  // Byte latched last cycle
            case (state)
               LOAD_1:  ctrl.res = RES_CONST_1;
               LOAD_2:  ctrl.res = RES_CONST_2;
               LOAD_3:  ctrl.res = RES_CONST_3;
               default: ctrl.res = RES_PC_HALF;
            endcase
            ctrl.rb_sel = dest(1'b0, REG_IDX_W'(state - LOAD_1));
         end
         FETCH: begin
            ctrl.res = RES_PC_HALF;
            ctrl.ale = 1'b1;
         end
         DECODE: begin
            ctrl.res   = RES_PC_INC;
            ctrl.ir_we = 1'b1;
            ctrl.pc_we = 1'b1;
         end
         EXEC_1: begin
            case (ir)
               ADD, SUB, MUL, NAND: begin
                  case (ir)
                     ADD:     ctrl.res = RES_SUM;
                     SUB:     ctrl.res = RES_DIFF;
                     MUL:     ctrl.res = RES_PROD;
                     default: ctrl.res = RES_NAND;
                  endcase
                  ctrl.rb_we  = 1'b1;
                  ctrl.rb_sel = dest(1'b1, '0);
               end
               SWAP_01, SWAP_12, SWAP_23: begin
                  ctrl.res    = swap_res;
                  ctrl.rb_we  = 1'b1;
                  ctrl.rb_sel = dest(1'b1, swap_lo);
               end
               BEQ: begin
                  ctrl.res   = RES_R3;
                  ctrl.pc_we = z;
               end
               PUSH_PC, PUSH_R2: begin
                  ctrl.res = RES_SP;
                  ctrl.ale = 1'b1;
               end
               POP_R2: begin
                  ctrl.res   = RES_SP_INC;
                  ctrl.sp_we = 1'b1;
                  ctrl.ale   = 1'b1;
               end
               LOAD, STORE: begin
                  ctrl.res = RES_R3;
                  ctrl.ale = 1'b1;
               end
               RELOAD_R0: begin
                  ctrl.res = RES_CONST_0;
                  ctrl.ale = 1'b1;
               end
               default: ;  // NOP_8 and NOP_F
            endcase
         end
         EXEC_2: begin
            case (ir)
               SWAP_01, SWAP_12, SWAP_23: begin
                  ctrl.res    = swap_res;
                  ctrl.rb_we  = 1'b1;
                  ctrl.rb_sel = dest(1'b1, swap_hi);
               end
               PUSH_PC, PUSH_R2: begin
                  ctrl.res   = RES_SP_DEC;
                  ctrl.sp_we = 1'b1;
               end
               POP_R2, LOAD: begin
                  ctrl.rb_we  = 1'b1;
                  ctrl.rb_sel = dest(1'b0, 2'd2);
               end
               STORE: begin
                  ctrl.res    = RES_R2;
                  ctrl.mem_we = 1'b1;
               end
               RELOAD_R0: begin
                  ctrl.rb_we  = 1'b1;
                  ctrl.rb_sel = dest(1'b0, 2'd0);
               end
               default: ;
            endcase
         end
         EXEC_3: begin
            case (ir)
               SWAP_01, SWAP_12, SWAP_23: begin
                  ctrl.res    = swap_res;
                  ctrl.rb_we  = 1'b1;
                  ctrl.rb_sel = dest(1'b1, swap_lo);
               end
               PUSH_PC: begin
                  ctrl.res    = RES_PC_DEC;  // pc already advanced
                  ctrl.mem_we = 1'b1;
               end
               PUSH_R2: begin
                  ctrl.res    = RES_R2;
                  ctrl.mem_we = 1'b1;
               end
               default: ;
            endcase
         end
         default: ;
      endcase
   end

   a_we_ale_excl: assert property (@(posedge clk) disable iff (!nRst)
      !(ctrl.mem_we && ctrl.ale));

   a_idle_quiet: assert property (@(posedge clk) disable iff (!nRst)
      state == IDLE |-> !(ctrl.ir_we || ctrl.pc_we || ctrl.sp_we ||
                          ctrl.rb_we || ctrl.mem_we));

endmodule

`default_nettype wire

/* src/up_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module up_datapath (
   input  logic            clk,
   input  logic            nRst,
   input  up_pkg::ctrl_t   ctrl,
   input  up_pkg::word_t   rd_data,
   output up_pkg::word_t   result,
   output up_pkg::opcode_e ir,
   output logic            z
);

   import up_pkg::*;

   word_t regs [REG_COUNT];
   word_t pc;  // Nibble address
   word_t sp;
   word_t r0;
   word_t r1;
   word_t r2;
   word_t r3;

   assign r0 = regs[0];
   assign r1 = regs[1];
   assign r2 = regs[2];
   assign r3 = regs[3];

   assign z = (r1 == r2);

   always_comb begin
      case (ctrl.res)
         RES_SUM:     result = r1 + r2;
         RES_DIFF:    result = r1 - r2;
         RES_PROD:    result = r1 * r2;  // Low byte only
         RES_NAND:    result = ~(r1 & r2);
         RES_XOR_01:  result = r0 ^ r1;
         RES_XOR_12:  result = r1 ^ r2;
         RES_XOR_23:  result = r2 ^ r3;
         RES_CONST_0: result = word_t'(0);
         RES_CONST_1: result = word_t'(1);
         RES_CONST_2: result = word_t'(2);
         RES_CONST_3: result = word_t'(3);
         RES_PC_HALF: result = {1'b0, pc[DATA_W-1:1]};
         RES_PC_INC:  result = pc + 1'b1;
         RES_PC_DEC:  result = pc - 1'b1;
         RES_R3:      result = r3;
         RES_R2:      result = r2;
         RES_SP:      result = sp;
         RES_SP_INC:  result = sp + 1'b1;
         RES_SP_DEC:  result = sp - 1'b1;
         default:     result = rd_data;
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc <= PC_RESET;
         sp <= SP_RESET;
         ir <= ADD;
      end else begin
         if (ctrl.pc_we) pc <= result;
         if (ctrl.sp_we) sp <= result;
         if (ctrl.ir_we) begin
            // Even nibble address is the high nibble
            if (pc[0]) ir <= opcode_e'(rd_data[3:0]);
            else       ir <= opcode_e'(rd_data[7:4]);
         end
      end
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (ctrl.rb_we) begin
         if (ctrl.rb_sel.from_result) regs[ctrl.rb_sel.idx] <= result;
         else                         regs[ctrl.rb_sel.idx] <= rd_data;
      end
   end

   // Decode and register write-back are separate cycles
   a_ir_rb_excl: assert property (@(posedge clk) disable iff (!nRst)
      !(ctrl.ir_we && ctrl.rb_we));

   // Stack pointer only moves by one per update
   a_sp_step: assert property (@(posedge clk) disable iff (!nRst)
      ctrl.sp_we |=> (sp == $past(sp) + 1'b1) || (sp == $past(sp) - 1'b1));

endmodule

`default_nettype wire

/* src/up_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module up_memory (
   input  logic               clk,
   input  logic               nRst,
   input  up_pkg::ctrl_t      ctrl,
   input  up_pkg::word_t      result,
   input  up_pkg::mem_write_t host_wr,
   output up_pkg::word_t      rd_data,
   output up_pkg::mem_write_t cpu_write
);

   import up_pkg::*;

   word_t mem [MEM_DEPTH];
   word_t addr_latch;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         addr_latch <= '0;
      end else if (ctrl.ale) begin
         addr_latch <= result;
      end
   end

   always_ff @(posedge clk) begin
      if (ctrl.mem_we)        mem[addr_latch]  <= result;
      else if (host_wr.valid) mem[host_wr.addr] <= host_wr.data;  // Only while idle
   end

   assign rd_data = mem[addr_latch];

   assign cpu_write.valid = ctrl.mem_we;
   assign cpu_write.addr  = addr_latch;
   assign cpu_write.data  = result;

   a_host_cpu_excl: assert property (@(posedge clk) disable iff (!nRst)
      !(host_wr.valid && ctrl.mem_we));

endmodule

`default_nettype wire

/* src/up_core.sv */
`timescale 1ns/1ps
`default_nettype none

module up_core (
   input  logic               clk,
   input  logic               nRst,
   input  logic               start,
   input  up_pkg::mem_write_t host_wr,
   output up_pkg::mem_write_t cpu_write
);

   import up_pkg::*;

   ctrl_t   ctrl;
   opcode_e ir;
   logic    z;
   word_t   result;
   word_t   rd_data;

   up_controller up_controller_inst (
      .clk   (clk),
      .nRst  (nRst),
      .start (start),
      .ir    (ir),
      .z     (z),
      .ctrl  (ctrl)
   );

   up_datapath up_datapath_inst (
      .clk     (clk),
      .nRst    (nRst),
      .ctrl    (ctrl),
      .rd_data (rd_data),
      .result  (result),
      .ir      (ir),
      .z       (z)
   );

   up_memory up_memory_inst (
      .clk       (clk),
      .nRst      (nRst),
      .ctrl      (ctrl),
      .result    (result),
      .host_wr   (host_wr),
      .rd_data   (rd_data),
      .cpu_write (cpu_write)
   );

endmodule

`default_nettype wire

/* verif/up_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module up_core_tb;

   import up_pkg::*;

   localparam int CLK_PERIOD = 10;
   localparam int DRIVE_SKEW = 1;
   localparam int DRAIN_CYCLES = 50;

   logic       clk;
   logic       nRst;
   logic       start;
   mem_write_t host_wr;
   mem_write_t cpu_write;

   word_t      load_addr [$];
   word_t      load_data [$];
   word_t      exp_addr [$];
   word_t      exp_data [$];

   int         w_idx;
   bit         started;
   bit         vectors_ready;
   int         fd;
   int         code;
   int         a;
   int         d;
   reg [8*8-1:0]   tag;
   reg [8*128-1:0] line;

   up_core up_core_inst (
      .clk       (clk),
      .nRst      (nRst),
      .start     (start),
      .host_wr   (host_wr),
      .cpu_write (cpu_write)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic halt_on_failure();
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic report_problem(input string msg);
      $display("%s", msg);
      halt_on_failure();
   endtask

   task automatic compare_value(input string name, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         $display("Error at %0t: %s expected %02h, got %02h", $time, name, expected, actual);
         halt_on_failure();
      end
   endtask

   // Processor writes checked in order at the falling edge
   always @(negedge clk) begin
      if (nRst && cpu_write.valid) begin
         if (!started) begin
            report_problem("The processor wrote memory before the start strobe");
         end else if (w_idx >= exp_addr.size()) begin
            report_problem("The processor made a write beyond the expected list");
         end else begin
            compare_value("cpu_write.addr", exp_addr[w_idx], cpu_write.addr);
            compare_value("cpu_write.data", exp_data[w_idx], cpu_write.data);
            w_idx++;
         end
      end
   end

   // Watchdog sized from the vector counts
   initial begin
      wait (vectors_ready);
      #(CLK_PERIOD * (load_addr.size() + 64 * exp_addr.size() + 100));
      $display("Timeout: only %0d of %0d expected processor writes arrived",
               w_idx, exp_addr.size());
      halt_on_failure();
   end

   initial begin
      clk           = 1'b0;
      nRst          = 1'b0;
      start         = 1'b0;
      host_wr       = '0;
      w_idx         = 0;
      started       = 1'b0;
      vectors_ready = 1'b0;

      fd = $fopen("verif/up_core_vectors.txt", "r");
      if (fd == 0) begin
         report_problem("Could not open verif/up_core_vectors.txt");
      end
      while (!$feof(fd)) begin
         code = $fscanf(fd, "%s", tag);
         if (code != 1) break;
         if (tag == "L") begin
            code = $fscanf(fd, "%h %h", a, d);
            if (code != 2) report_problem("Malformed L line in the vectors file");
            load_addr.push_back(word_t'(a));
            load_data.push_back(word_t'(d));
         end else if (tag == "W") begin
            code = $fscanf(fd, "%h %h", a, d);
            if (code != 2) report_problem("Malformed W line in the vectors file");
            exp_addr.push_back(word_t'(a));
            exp_data.push_back(word_t'(d));
         end else begin
            code = $fgets(line, fd);  // Comment line
         end
      end
      $fclose(fd);
      if (exp_addr.size() == 0) begin
         report_problem("The vectors file holds no expected writes");
      end
      vectors_ready = 1'b1;

      repeat (3) @(posedge clk);
      #DRIVE_SKEW nRst = 1'b1;

      // Host image load one byte per cycle
      foreach (load_addr[i]) begin
         @(posedge clk);
         #DRIVE_SKEW;
         host_wr.valid = 1'b1;
         host_wr.addr  = load_addr[i];
         host_wr.data  = load_data[i];
      end
      @(posedge clk);
      #DRIVE_SKEW;
      host_wr = '0;
      start   = 1'b1;
      started = 1'b1;
      @(posedge clk);
      #DRIVE_SKEW start = 1'b0;

      wait (w_idx == exp_addr.size());
      repeat (DRAIN_CYCLES) @(posedge clk);

      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
src/up_pkg.sv
src/up_controller.sv
src/up_datapath.sv
src/up_memory.sv
src/up_core.sv
verif/up_core_tb.sv

/* Bender.yml */
package:
  name: up_core

sources:
  - src/up_pkg.sv
  - src/up_controller.sv
  - src/up_datapath.sv
  - src/up_memory.sv
  - src/up_core.sv
  - target: test
    files:
      - verif/up_core_tb.sv

/* verif/up_core_vectors.txt */
# L addr data: memory image byte loaded by the host (hex)
# W addr data: expected processor write, in order (hex)
# Registers r0 to r3
L 00 76
L 01 C8
L 02 5A
L 03 40
# Program from nibble 08
L 04 D0
L 05 45
L 06 7D
L 07 14
L 08 5D
L 09 24
L 0A 5D
L 0B 34
L 0C 5D
L 0D 6C
L 0E D9
L 0F B6
L 10 AD
L 11 E5
L 12 67
L 13 DF
# Branch target at nibble 70 and the final loop at nibble 76
L 38 D4
L 39 56
L 3A 54
L 3B 7F
# Data read by LOAD
L CF 9E
# Expected writes
W 40 5A
W 40 22
W 40 38
W 40 70
W 40 CF
W CF 9E
W FF 1D
W FE 9E
W 9E 9E
W 70 9E
